// File: ssio_rx.f
src/ssio_rx_pkg.sv
src/ssio_ddr_in.sv
src/ssio_ddr_in_diff.sv
src/lane_aligner.sv
src/rx_wb_regs.sv
src/ssio_rx_top.sv
verification/ssio_rx_asserts.sv
verification/ssio_rx_tb.sv

// File: verification/ssio_rx_tb.sv
// module ssio_rx_tb: clocking, stimulus table, lane serializer, wishbone master and checks
`timescale 1ns/1ps
`default_nettype none

module ssio_rx_tb;
    import ssio_rx_pkg::*;

    localparam int clk_half = 2;
    localparam int ack_timeout = 16;
    localparam int poll_limit = 300;
    localparam int row_count = 3;
    localparam int buf_mask = 4095;

    typedef struct packed {
        logic [3:0][2:0]              skew;
        int                           train_count;
        int                           n_words;
        logic                         rnd;
        logic [9:0][word_width-1:0]   words;
        logic [word_width-1:0]        exp_status;
    } row_t;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic input_clk_p = 1'b0;
    logic input_clk_n;
    logic [lane_count-1:0] input_d_p = '0;
    logic [lane_count-1:0] input_d_n = '1;
    logic output_clk;
    logic wb_cyc = 1'b0;
    logic wb_stb = 1'b0;
    logic wb_we = 1'b0;
    reg_addr_t wb_adr = reg_status;
    logic [word_width-1:0] wb_dat_w = '0;
    logic [word_width-1:0] wb_dat_r;
    logic wb_ack;

    // per-lane bit buffers, oldest bit at rd_pos
    logic lane_bits [lane_count][buf_mask+1];
    int wr_pos [lane_count];
    int rd_pos [lane_count];
    logic idle_train = 1'b0;
    row_t rows [row_count];

    ssio_rx_top dut_i (
        .input_clk_p (input_clk_p), .input_clk_n (input_clk_n),
        .input_d_p   (input_d_p),   .input_d_n   (input_d_n),
        .rst         (rst),         .output_clk  (output_clk),
        .wb_cyc      (wb_cyc),      .wb_stb      (wb_stb),
        .wb_we       (wb_we),       .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),    .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack)
    );

    initial begin
        forever #clk_half clk = ~clk;
    end

    // forwarded clock lags the data by a quarter period
    always @(clk) input_clk_p <= #1 clk;
    assign input_clk_n = ~input_clk_p;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic push_byte(input int lane, input logic [byte_width-1:0] b);
        for (int k = byte_width - 1; k >= 0; k--) begin
            lane_bits[lane][wr_pos[lane] & buf_mask] = b[k];
            wr_pos[lane]++;
        end
    endtask

    // two bits per lane per period, second one half a period later
    task automatic drive_pair();
        logic [lane_count-1:0] first;
        logic [lane_count-1:0] second;
        for (int i = 0; i < lane_count; i++) begin
            if (wr_pos[i] - rd_pos[i] < 2) begin
                push_byte(i, idle_train ? train_word : 8'h00);
            end
            first[i] = lane_bits[i][rd_pos[i] & buf_mask];
            second[i] = lane_bits[i][(rd_pos[i] + 1) & buf_mask];
            rd_pos[i] += 2;
        end
        input_d_p <= first;
        input_d_n <= ~first;
        input_d_p <= #2 second;
        input_d_n <= #2 ~second;
    endtask

    always @(posedge clk) drive_pair();

    task automatic check_clock(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: output_clk got 0x%h expected 0x%h", got, exp);
            stop_on_error("forwarded clock mismatch");
        end
    endtask

    // output_clk must follow the p leg of the forwarded clock
    always @(clk) check_clock(output_clk, input_clk_p);

    task automatic wb_access(input reg_addr_t adr, input logic we,
                             input logic [word_width-1:0] wdata,
                             output logic [word_width-1:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr;
        wb_dat_w <= wdata;
        do begin
            @(posedge clk);
            waited++;
            if (waited > ack_timeout) stop_on_error("no wishbone acknowledge");
        end while (!wb_ack);
        rdata = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic wb_read(input reg_addr_t adr, output logic [word_width-1:0] rdata);
        wb_access(adr, 1'b0, '0, rdata);
    endtask

    task automatic wb_write(input reg_addr_t adr, input logic [word_width-1:0] wdata);
        logic [word_width-1:0] unused;
        wb_access(adr, 1'b1, wdata, unused);
    endtask

    task automatic check_word(input string name, input logic [word_width-1:0] got,
                              input logic [word_width-1:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error("data mismatch");
        end
    endtask

    // field by field against the status layout
    task automatic check_status(input logic [word_width-1:0] got,
                                input logic [word_width-1:0] exp);
        check_word("status lock", got[lane_count-1:0], exp[lane_count-1:0]);
        check_word("status overflow", got[8], exp[8]);
        check_word("status level", got[16 +: fifo_level_width], exp[16 +: fifo_level_width]);
        check_word("status", got, exp);
    endtask

    task automatic poll_status(input int bit_lo, input int bits_set, input string what);
        logic [word_width-1:0] st;
        int polls;
        polls = 0;
        do begin
            wb_read(reg_status, st);
            polls++;
            if (polls > poll_limit) stop_on_error(what);
        end while ((st >> bit_lo) % (1 << $clog2(bits_set + 1)) != bits_set);
    endtask

    task automatic load_table();
        rows[0] = '{skew: {3'd3, 3'd2, 3'd1, 3'd0}, train_count: 16, n_words: 3, rnd: 1'b0,
                    words: {224'h0, 32'h00ff7e81, 32'ha5c3e10f, 32'h11223344},
                    exp_status: 32'h0008_010f};
        rows[1] = '{skew: {3'd1, 3'd3, 3'd0, 3'd5}, train_count: 16, n_words: 10, rnd: 1'b0,
                    words: {32'h99aabbcc, 32'h8899aabb, 32'h778899aa, 32'h66778899,
                            32'h55667788, 32'h44556677, 32'h33445566, 32'h22334455,
                            32'h11223344, 32'h01020304},
                    exp_status: 32'h0008_010f};
        rows[2] = '{skew: {3'd5, 3'd0, 3'd4, 3'd2}, train_count: 16, n_words: 5, rnd: 1'b1,
                    words: '0, exp_status: 32'h0008_010f};
    endtask

    initial begin
        logic [word_width-1:0] rd;
        row_t row;
        void'($urandom(32'h6efdac17));
        for (int i = 0; i < lane_count; i++) begin
            wr_pos[i] = 0;
            rd_pos[i] = 0;
        end
        load_table();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        wb_read(reg_status, rd);
        check_status(rd, '0);
        wb_read(reg_data, rd);
        check_word("wb_dat_r", rd, '0);
        for (int r = 0; r < row_count; r++) begin
            row = rows[r];
            if (row.rnd) begin
                for (int w = 0; w < row.n_words; w++) row.words[w] = $urandom;
            end
            // the first payload byte of a lane must not look like training
            for (int i = 0; i < lane_count; i++) begin
                if (row.words[0][i*byte_width +: byte_width] == train_word) begin
                    row.words[0][i*byte_width] = ~row.words[0][i*byte_width];
                end
            end
            @(negedge clk);
            for (int i = 0; i < lane_count; i++) begin
                // all lanes restart from the same bit so only the table skew separates them
                wr_pos[i] = rd_pos[i];
                for (int s = 0; s < row.skew[i]; s++) begin
                    lane_bits[i][wr_pos[i] & buf_mask] = 1'b0;
                    wr_pos[i]++;
                end
                for (int t = 0; t < row.train_count; t++) push_byte(i, train_word);
                for (int w = 0; w < row.n_words; w++) begin
                    push_byte(i, row.words[w][i*byte_width +: byte_width]);
                end
            end
            idle_train = 1'b1;
            poll_status(0, 15, "lanes did not lock");
            // idle training words keep arriving until the fifo overflows
            poll_status(8, 1, "overflow never set");
            wb_read(reg_status, rd);
            check_status(rd, row.exp_status);
            for (int w = 0; w < row.n_words && w < fifo_depth; w++) begin
                wb_read(reg_data, rd);
                check_word("wb_dat_r", rd, row.words[w]);
            end
            wb_read(reg_data, rd);
            check_word("wb_dat_r", rd, {lane_count{train_word}});
            idle_train = 1'b0;
            repeat (12) @(posedge clk);
            // second write empties holders that a late lane byte refilled
            wb_write(reg_ctrl, 32'h1);
            wb_write(reg_ctrl, 32'h1);
            wb_read(reg_status, rd);
            check_status(rd, '0);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/ssio_rx_asserts.sv
// module ssio_rx_asserts and its bind: wishbone handshake, fifo level and realign checks
`timescale 1ns/1ps
`default_nettype none

module ssio_rx_asserts (
    input logic                                     clk,
    input logic                                     rst,
    input logic                                     wb_cyc,
    input logic                                     wb_stb,
    input logic                                     wb_ack,
    input logic                                     realign,
    input logic [ssio_rx_pkg::fifo_level_width-1:0] level
);
    import ssio_rx_pkg::*;

    // ack answers a request seen one cycle earlier
    ack_after_request: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("ack without a preceding request");

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else $error("ack held longer than one cycle");

    level_in_range: assert property (@(posedge clk) disable iff (rst)
        level <= fifo_level_width'(fifo_depth))
        else $error("fifo level above depth");

    realign_pulse: assert property (@(posedge clk) disable iff (rst)
        realign |=> !realign)
        else $error("realign longer than one cycle");

endmodule

bind rx_wb_regs ssio_rx_asserts asserts_i (
    .clk     (clk),
    .rst     (rst),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_ack  (wb_ack),
    .realign (realign),
    .level   (level)
);

`default_nettype wire

// File: src/ssio_rx_top.sv
// module ssio_rx_top: differential ddr input, four lane aligners and the wishbone register slave
`timescale 1ns/1ps
`default_nettype none

module ssio_rx_top (
    input  logic                               input_clk_p,
    input  logic                               input_clk_n,
    input  logic [ssio_rx_pkg::lane_count-1:0] input_d_p,
    input  logic [ssio_rx_pkg::lane_count-1:0] input_d_n,
    input  logic                               rst,
    output logic                               output_clk,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  ssio_rx_pkg::reg_addr_t             wb_adr,
    input  logic [ssio_rx_pkg::word_width-1:0] wb_dat_w,
    output logic [ssio_rx_pkg::word_width-1:0] wb_dat_r,
    output logic                               wb_ack
);
    import ssio_rx_pkg::*;

    logic [lane_count-1:0] q1;
    logic [lane_count-1:0] q2;
    logic [byte_width-1:0] lane_byte [lane_count];
    logic [lane_count-1:0] byte_valid;
    logic [lane_count-1:0] locked;
    logic                  realign;

    ssio_ddr_in_diff ddr_in_diff_inst (
        .input_clk_p (input_clk_p),
        .input_clk_n (input_clk_n),
        .input_d_p   (input_d_p),
        .input_d_n   (input_d_n),
        .output_clk  (output_clk),
        .output_q1   (q1),
        .output_q2   (q2)
    );

    // one aligner per lane, all sharing the realign pulse
    for (genvar i = 0; i < lane_count; i++) begin : g_lane
        lane_aligner lane_aligner_inst (
            .clk        (output_clk),
            .rst        (rst),
            .realign    (realign),
            .q1         (q1[i]),
            .q2         (q2[i]),
            .lane_byte  (lane_byte[i]),
            .byte_valid (byte_valid[i]),
            .locked     (locked[i])
        );
    end

    rx_wb_regs rx_wb_regs_inst (
        .clk        (output_clk),
        .rst        (rst),
        .lane_byte  (lane_byte),
        .byte_valid (byte_valid),
        .locked     (locked),
        .realign    (realign),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack)
    );

endmodule

`default_nettype wire

// File: src/rx_wb_regs.sv
// module rx_wb_regs: lane byte collector, receive word fifo and wishbone classic register slave
`timescale 1ns/1ps
`default_nettype none

module rx_wb_regs (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [ssio_rx_pkg::byte_width-1:0] lane_byte [ssio_rx_pkg::lane_count],
    input  logic [ssio_rx_pkg::lane_count-1:0] byte_valid,
    input  logic [ssio_rx_pkg::lane_count-1:0] locked,
    output logic                               realign,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  ssio_rx_pkg::reg_addr_t             wb_adr,
    input  logic [ssio_rx_pkg::word_width-1:0] wb_dat_w,
    output logic [ssio_rx_pkg::word_width-1:0] wb_dat_r,
    output logic                               wb_ack
);
    import ssio_rx_pkg::*;

    logic [byte_width-1:0]         hold_byte [lane_count];
    logic [lane_count-1:0]         hold_full;
    logic [word_width-1:0]         word_in;
    logic                          push;
    logic                          wr_en;
    logic [word_width-1:0]         fifo_mem [fifo_depth];
    logic [$clog2(fifo_depth)-1:0] wr_ptr;
    logic [$clog2(fifo_depth)-1:0] rd_ptr;
    logic [fifo_level_width-1:0]   level;
    logic                          fifo_full;
    logic                          fifo_empty;
    logic                          overflow;
    logic                          wb_req;
    logic                          pop;
    logic                          ctrl_clear;
    logic [word_width-1:0]         status_word;

    // a word leaves the holders once every lane has delivered
    assign push  = &hold_full;
    assign wr_en = push && !fifo_full;

    assign fifo_full  = (level == fifo_level_width'(fifo_depth));
    assign fifo_empty = (level == '0);

    // new request only while no ack is out
    assign wb_req     = wb_cyc && wb_stb && !wb_ack;
    assign pop        = wb_req && !wb_we && (wb_adr == reg_data) && !fifo_empty;
    assign ctrl_clear = wb_req && wb_we && (wb_adr == reg_ctrl) && wb_dat_w[0];

    always_comb begin
        for (int i = 0; i < lane_count; i++) begin
            word_in[i*byte_width +: byte_width] = hold_byte[i];
        end
    end

    always_comb begin
        status_word                          = '0;
        status_word[lane_count-1:0]          = locked;
        status_word[8]                       = overflow;
        status_word[16 +: fifo_level_width]  = level;
    end

    // per-lane holders, a lane refills in the cycle its word leaves
    always_ff @(posedge clk) begin
        if (rst || ctrl_clear) begin
            hold_full <= '0;
        end else if (push) begin
            hold_full <= byte_valid;
        end else begin
            hold_full <= hold_full | byte_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < lane_count; i++) begin
            if (byte_valid[i] && (!hold_full[i] || push)) begin
                hold_byte[i] <= lane_byte[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            fifo_mem[wr_ptr] <= word_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || ctrl_clear) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // sticky until the next control write
            if (push && fifo_full) begin
                overflow <= 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // ack and realign both land one cycle after the request
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack  <= 1'b0;
            realign <= 1'b0;
        end else begin
            wb_ack  <= wb_req;
            realign <= ctrl_clear;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_req) begin
            case (wb_adr)
                reg_status: wb_dat_r <= status_word;
                reg_data:   wb_dat_r <= fifo_empty ? '0 : fifo_mem[rd_ptr];
                default:    wb_dat_r <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/lane_aligner.sv
// module lane_aligner: training word search, byte boundary lock and byte stream for one lane
`timescale 1ns/1ps
`default_nettype none

module lane_aligner (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               realign,
    input  logic                               q1,
    input  logic                               q2,
    output logic [ssio_rx_pkg::byte_width-1:0] lane_byte,
    output logic                               byte_valid,
    output logic                               locked
);
    import ssio_rx_pkg::*;

    // latest nine bits, oldest at the top
    logic [byte_width:0]   hist;
    logic [byte_width:0]   hist_next;
    logic [byte_width-1:0] win_q1;
    logic [byte_width-1:0] win_q2;
    logic [byte_width-1:0] cand;
    align_state_t          state;
    // set when the byte ends on the rising bit
    logic                  offset;
    logic [1:0]            phase;
    logic                  byte_due;

    // q1 arrives before q2 so it shifts in first
    assign hist_next = {hist[byte_width-2:0], q1, q2};
    assign win_q1    = hist_next[byte_width:1];
    assign win_q2    = hist_next[byte_width-1:0];
    assign cand      = offset ? win_q1 : win_q2;

    // four cycles carry eight bits
    assign byte_due = (phase == 2'd3);
    assign locked   = (state != st_search);

    always_ff @(posedge clk) begin
        hist <= hist_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_search;
            offset     <= 1'b0;
            phase      <= 2'd0;
            byte_valid <= 1'b0;
        end else if (realign) begin
            state      <= st_search;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            phase      <= phase + 2'd1;
            case (state)
                st_search: begin
                    if (win_q1 == train_word) begin
                        offset <= 1'b1;
                        phase  <= 2'd0;
                        state  <= st_locked;
                    end else if (win_q2 == train_word) begin
                        offset <= 1'b0;
                        phase  <= 2'd0;
                        state  <= st_locked;
                    end
                end
                st_locked: begin
                    // training bytes are swallowed until the first payload byte
                    if (byte_due && cand != train_word) begin
                        lane_byte  <= cand;
                        byte_valid <= 1'b1;
                        state      <= st_stream;
                    end
                end
                st_stream: begin
                    if (byte_due) begin
                        lane_byte  <= cand;
                        byte_valid <= 1'b1;
                    end
                end
                default: state <= st_search;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/ssio_ddr_in_diff.sv
// module ssio_ddr_in_diff: differential pair resolution in front of the ddr capture
`timescale 1ns/1ps
`default_nettype none

module ssio_ddr_in_diff (
    input  logic                               input_clk_p,
    input  logic                               input_clk_n,
    input  logic [ssio_rx_pkg::lane_count-1:0] input_d_p,
    input  logic [ssio_rx_pkg::lane_count-1:0] input_d_n,
    output logic                               output_clk,
    output logic [ssio_rx_pkg::lane_count-1:0] output_q1,
    output logic [ssio_rx_pkg::lane_count-1:0] output_q2
);
    import ssio_rx_pkg::*;

    logic                  input_clk;
    logic [lane_count-1:0] input_d;

    // p leg carries the value, equal legs mean a broken pair
    function automatic logic resolve_pair(input logic p, input logic n);
        return (p == n) ? 1'bx : p;
    endfunction

    // clock uses the p leg alone so a late n leg adds no edges
    assign input_clk = input_clk_p;

    for (genvar i = 0; i < lane_count; i++) begin : g_data_pair
        assign input_d[i] = resolve_pair(input_d_p[i], input_d_n[i]);
    end

    ssio_ddr_in ddr_in_inst (
        .input_clk  (input_clk),
        .input_d    (input_d),
        .output_clk (output_clk),
        .output_q1  (output_q1),
        .output_q2  (output_q2)
    );

endmodule

`default_nettype wire

// File: src/ssio_ddr_in.sv
// module ssio_ddr_in: generic dual-edge capture with both samples presented on the rising edge
`timescale 1ns/1ps
`default_nettype none

module ssio_ddr_in (
    input  logic                               input_clk,
    input  logic [ssio_rx_pkg::lane_count-1:0] input_d,
    output logic                               output_clk,
    output logic [ssio_rx_pkg::lane_count-1:0] output_q1,
    output logic [ssio_rx_pkg::lane_count-1:0] output_q2
);
    import ssio_rx_pkg::*;

    // first bit of the pair
    logic [lane_count-1:0] d_rise;
    // second bit, held across the falling edge
    logic [lane_count-1:0] d_fall;

    // the receive path runs on the forwarded clock itself
    assign output_clk = input_clk;

    always_ff @(posedge input_clk) begin
        d_rise <= input_d;
    end

    always_ff @(negedge input_clk) begin
        d_fall <= input_d;
    end

    // realign the pair so q1 and q2 belong to the same period
    always_ff @(posedge input_clk) begin
        output_q1 <= d_rise;
        output_q2 <= d_fall;
    end

endmodule

`default_nettype wire

// File: src/ssio_rx_pkg.sv
// package ssio_rx_pkg: lane and word sizes, training word, fifo sizing, register and aligner enums
`default_nettype none

package ssio_rx_pkg;

    // link geometry
    localparam int lane_count = 4;
    localparam int byte_width = 8;
    localparam int word_width = lane_count * byte_width;

    // pattern each lane repeats until its receiver locks
    localparam logic [byte_width-1:0] train_word = 8'hb4;

    // receive word fifo
    localparam int fifo_depth = 8;
    localparam int fifo_level_width = 4;

    // wishbone word addresses
    typedef enum logic [1:0] {
        reg_status = 2'd0,
        reg_data   = 2'd1,
        reg_ctrl   = 2'd2
    } reg_addr_t;

    typedef enum logic [1:0] {
        st_search,
        st_locked,
        st_stream
    } align_state_t;

endpackage

`default_nettype wire
